// File: dv/snakeChecker.sv
/*
 * Snake engine checker. Follows the pixel stream block by block, keeps its
 * own model of body, apple and score, and compares every block with it.
 */
`timescale 1ns/1ns
`include "snakeParams.svh"

module snakeChecker
(
    input  logic                  Clock,
    input  logic                  reset,
    input  logic                  plot,
    input  snakePkg::pixelWrite_t pixel,
    input  logic [6:0]            scoreSegments,
    input  logic                  gameOver,
    input  snakePkg::colour_t     snakeColour,
    input  snakePkg::xCoord_t     expHeadX,
    input  snakePkg::yCoord_t     expHeadY,
    input  snakePkg::scoreDigit_t expScore,
    input  logic                  expOver,
    output int                    drawCount,
    output logic                  endSeen,
    output int                    errorCount,
    output int                    checkCount
);
    import snakePkg::*;

    // model of the body, index 0 is the head
    xCoord_t bodyX [0:`SNAKE_LEN-1];
    yCoord_t bodyY [0:`SNAKE_LEN-1];
    // apple walk, entry 0 only at reset
    int      appleTableX [0:6] = '{30, 10, 70, 60, 20, 50, 80};
    int      appleTableY [0:6] = '{30, 20, 90, 100, 80, 10, 50};
    int      appleIdx;
    // position inside the current 10x10 block
    int      pixIdx;
    int      eraseIdx;
    int      snakeIdx;
    xCoord_t blockX;
    yCoord_t blockY;
    colour_t blockColour;
    logic    applePending;
    logic    moved;
    logic    modelHit;
    logic    endDone;
    logic    afterReset;

    // lit segments a..g on bits 0..6, then inverted for the active-low pins
    function automatic logic [6:0] segmentsFor(input int digit);
        logic [6:0] lit;
        case (digit)
            0: lit = 7'h3f;
            1: lit = 7'h06;
            2: lit = 7'h5b;
            3: lit = 7'h4f;
            4: lit = 7'h66;
            5: lit = 7'h6d;
            6: lit = 7'h7d;
            7: lit = 7'h07;
            8: lit = 7'h7f;
            9: lit = 7'h67;
            default: lit = 7'h00;
        endcase
        return ~lit;
    endfunction

    task automatic compareValue(input string name, input int got, input int expected);
        checkCount++;
        if (got != expected)
        begin
            errorCount++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic reportFailure(input string what);
        checkCount++;
        errorCount++;
        $display("error: %s at %0t", what, $time);
    endtask

    task automatic resetModel();
        for (int i = 0; i < `SNAKE_LEN; i++)
        begin
            bodyX[i] = xCoord_t'(`HEAD_X0);
            bodyY[i] = yCoord_t'(`HEAD_Y0 + i * `SEG_SIZE);
        end
        appleIdx     = 0;
        pixIdx       = 0;
        eraseIdx     = 0;
        snakeIdx     = 0;
        applePending = 1'b1;
        moved        = 1'b0;
        modelHit     = 1'b0;
        endDone      = 1'b0;
        afterReset   = 1'b1;
        drawCount    = 0;
        endSeen      = 1'b0;
    endtask

    // shift the body and place the head from the step table
    task automatic moveModel();
        for (int i = `SNAKE_LEN - 1; i > 0; i--)
        begin
            bodyX[i] = bodyX[i-1];
            bodyY[i] = bodyY[i-1];
        end
        bodyX[0] = expHeadX;
        bodyY[0] = expHeadY;
        if (int'(bodyX[0]) == appleTableX[appleIdx] && int'(bodyY[0]) == appleTableY[appleIdx])
        begin
            appleIdx     = (appleIdx == 6) ? 1 : appleIdx + 1;
            applePending = 1'b1;
        end
        modelHit = 1'b0;
        for (int i = `FIRST_CHECKED_SEG; i < `SNAKE_LEN; i++)
        begin
            if (bodyX[0] == bodyX[i] && bodyY[0] == bodyY[i])
                modelHit = 1'b1;
        end
        moved    = 1'b1;
        eraseIdx = 0;
    endtask

    // first block of a snake draw carries the new head
    task automatic startSnakeDraw();
        if (drawCount > 0 && !moved)
            reportFailure("snake drawn without an erase and move before it");
        if (applePending)
            reportFailure("apple not redrawn after an eat");
        if (modelHit)
            reportFailure("snake drawn after a self-hit");
        if (expOver)
            reportFailure("snake drawn where a self-hit was expected");
        compareValue("scoreSegments", scoreSegments, segmentsFor(expScore));
        moved = 1'b0;
        drawCount++;
    endtask

    task automatic startBlock();
        if (blockColour == `APPLE_COLOUR)
        begin
            if (!applePending)
                reportFailure("apple drawn without an eat");
            compareValue("apple pixel.x", blockX, appleTableX[appleIdx]);
            compareValue("apple pixel.y", blockY, appleTableY[appleIdx]);
            applePending = 1'b0;
        end
        else if (blockColour == `ERASE_COLOUR)
        begin
            if (eraseIdx >= `SNAKE_LEN)
                reportFailure("more erase blocks than segments");
            else
            begin
                compareValue("erase pixel.x", blockX, bodyX[eraseIdx]);
                compareValue("erase pixel.y", blockY, bodyY[eraseIdx]);
            end
            eraseIdx++;
        end
        else if (blockColour == snakeColour)
        begin
            if (snakeIdx == 0)
                startSnakeDraw();
            compareValue("snake pixel.x", blockX, bodyX[snakeIdx]);
            compareValue("snake pixel.y", blockY, bodyY[snakeIdx]);
            snakeIdx = (snakeIdx + 1) % `SNAKE_LEN;
        end
        else if (blockColour == `END_COLOUR)
        begin
            if (!modelHit)
                reportFailure("end marker drawn without a self-hit");
            if (!expOver)
                reportFailure("end marker drawn where no self-hit was expected");
            compareValue("end pixel.x", blockX, bodyX[0]);
            compareValue("end pixel.y", blockY, bodyY[0]);
            compareValue("scoreSegments", scoreSegments, segmentsFor(expScore));
        end
        else
            compareValue("pixel.colour", blockColour, snakeColour);
    endtask

    task automatic finishBlock();
        if (blockColour == `ERASE_COLOUR && eraseIdx == `SNAKE_LEN)
            moveModel();
        else if (blockColour == `END_COLOUR)
        begin
            endDone = 1'b1;
            endSeen = 1'b1;
        end
    endtask

    task automatic handlePixel();
        if (endDone)
        begin
            reportFailure("plot after the end marker");
            return;
        end
        if (pixIdx == 0)
        begin
            blockX      = pixel.x;
            blockY      = pixel.y;
            blockColour = pixel.colour;
            startBlock();
        end
        else
        begin
            // row by row sweep from the block origin
            compareValue("pixel.x", pixel.x, int'(blockX) + pixIdx % `SEG_SIZE);
            compareValue("pixel.y", pixel.y, int'(blockY) + pixIdx / `SEG_SIZE);
            compareValue("pixel.colour", pixel.colour, blockColour);
        end
        pixIdx++;
        if (pixIdx == `SEG_SIZE * `SEG_SIZE)
        begin
            pixIdx = 0;
            finishBlock();
        end
    endtask

    initial
    begin
        errorCount = 0;
        checkCount = 0;
        resetModel();
    end

    always @(posedge Clock)
    begin
        if (reset)
            resetModel();
        else
        begin
            if (afterReset)
            begin
                compareValue("scoreSegments", scoreSegments, segmentsFor(0));
                afterReset = 1'b0;
            end
            // gameOver only once the end marker is complete
            if (gameOver !== endDone)
                compareValue("gameOver", gameOver, endDone);
            if (plot)
                handlePixel();
        end
    end

endmodule

// File: dv/snakeTb.sv
/*
 * Snake engine testbench. Starts the game and steers the snake through a
 * table of steps: two eats, wraps at all four edges and a final self-hit.
 */
`timescale 1ns/1ns
`include "snakeParams.svh"

module snakeTb;
    import snakePkg::*;

    localparam int stepCount  = 23;
    localparam int cycleLimit = stepCount * (`STEP_TICKS + 1400) + 2000;

    // active-low key codes
    localparam logic [3:0] keyNone  = 4'b1111;
    localparam logic [3:0] keyRight = 4'b1110;
    localparam logic [3:0] keyDown  = 4'b1101;
    localparam logic [3:0] keyUp    = 4'b1011;
    localparam logic [3:0] keyLeft  = 4'b0111;

    typedef struct packed {
        logic [3:0]  keyN;
        xCoord_t     headX;
        yCoord_t     headY;
        scoreDigit_t score;
        logic        over;
    } stepEntry_t;

    stepEntry_t  steps [0:stepCount-1];

    logic        Clock;
    logic        reset;
    logic [3:0]  keyN;
    colour_t     snakeColour;
    logic        start;
    logic        plot;
    pixelWrite_t pixel;
    logic [6:0]  scoreSegments;
    logic        gameOver;

    xCoord_t     expHeadX;
    yCoord_t     expHeadY;
    scoreDigit_t expScore;
    logic        expOver;
    int          drawCount;
    logic        endSeen;
    int          errorCount;
    int          checkCount;
    int          cycleCount;
    int          runErrors;

    snakeTop UUT
    (
        .Clock         (Clock),
        .reset         (reset),
        .keyN          (keyN),
        .snakeColour   (snakeColour),
        .start         (start),
        .plot          (plot),
        .pixel         (pixel),
        .scoreSegments (scoreSegments),
        .gameOver      (gameOver)
    );

    snakeChecker streamCheck
    (
        .Clock         (Clock),
        .reset         (reset),
        .plot          (plot),
        .pixel         (pixel),
        .scoreSegments (scoreSegments),
        .gameOver      (gameOver),
        .snakeColour   (snakeColour),
        .expHeadX      (expHeadX),
        .expHeadY      (expHeadY),
        .expScore      (expScore),
        .expOver       (expOver),
        .drawCount     (drawCount),
        .endSeen       (endSeen),
        .errorCount    (errorCount),
        .checkCount    (checkCount)
    );

    always #2 Clock = ~Clock;

    function automatic stepEntry_t makeEntry(input logic [3:0] k, input int x, input int y,
                                             input int s, input logic o);
        stepEntry_t e;
        e.keyN  = k;
        e.headX = xCoord_t'(x);
        e.headY = yCoord_t'(y);
        e.score = scoreDigit_t'(s);
        e.over  = o;
        return e;
    endfunction

    // head after each step from the move and wrap rules
    task automatic loadTable();
        steps[0]  = makeEntry(keyLeft,  70,  60, 0, 1'b0);
        steps[1]  = makeEntry(keyLeft,  60,  60, 0, 1'b0);
        steps[2]  = makeEntry(keyLeft,  50,  60, 0, 1'b0);
        steps[3]  = makeEntry(keyLeft,  40,  60, 0, 1'b0);
        steps[4]  = makeEntry(keyLeft,  30,  60, 0, 1'b0);
        steps[5]  = makeEntry(keyUp,    30,  50, 0, 1'b0);
        steps[6]  = makeEntry(keyUp,    30,  40, 0, 1'b0);
        // lands on the first apple
        steps[7]  = makeEntry(keyUp,    30,  30, 1, 1'b0);
        steps[8]  = makeEntry(keyUp,    30,  20, 1, 1'b0);
        steps[9]  = makeEntry(keyLeft,  20,  20, 1, 1'b0);
        steps[10] = makeEntry(keyLeft,  10,  20, 2, 1'b0);
        steps[11] = makeEntry(keyLeft,   0,  20, 2, 1'b0);
        // wrap through the left edge
        steps[12] = makeEntry(keyLeft, 150,  20, 2, 1'b0);
        steps[13] = makeEntry(keyUp,   150,  10, 2, 1'b0);
        steps[14] = makeEntry(keyUp,   150,   0, 2, 1'b0);
        // wrap through the top edge
        steps[15] = makeEntry(keyUp,   150, 110, 2, 1'b0);
        steps[16] = makeEntry(keyRight,  0, 110, 2, 1'b0);
        steps[17] = makeEntry(keyRight, 10, 110, 2, 1'b0);
        steps[18] = makeEntry(keyRight, 20, 110, 2, 1'b0);
        // the head comes back onto its own body
        steps[19] = makeEntry(keyRight, 30, 110, 2, 1'b0);
        steps[20] = makeEntry(keyDown,  30,   0, 2, 1'b0);
        steps[21] = makeEntry(keyLeft,  20,   0, 2, 1'b0);
        steps[22] = makeEntry(keyUp,    20, 110, 2, 1'b1);
    endtask

    // block until the given snake draw starts or the end marker is done
    task automatic waitForDraw(input int target);
        while (drawCount < target && !endSeen)
        begin
            @(posedge Clock);
            #1;
        end
    endtask

    always @(posedge Clock)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("timeout after %0d cycles, the snake stopped moving", cycleCount);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        int errorsBefore;
        Clock       = 1'b0;
        reset       = 1'b1;
        keyN        = keyNone;
        snakeColour = 3'b010;
        start       = 1'b0;
        expHeadX    = xCoord_t'(`HEAD_X0);
        expHeadY    = yCoord_t'(`HEAD_Y0);
        expScore    = '0;
        expOver     = 1'b0;
        cycleCount  = 0;
        runErrors   = 0;
        loadTable();

        repeat (2) @(posedge Clock);
        #1;
        reset = 1'b0;
        start = 1'b1;
        @(posedge Clock);
        #1;
        start = 1'b0;

        waitForDraw(1);
        $display("initial draw: %s", (errorCount == 0) ? "ok" : "FAILED");
        errorsBefore = errorCount;

        for (int i = 0; i < stepCount; i++)
        begin
            keyN     = steps[i].keyN;
            expHeadX = steps[i].headX;
            expHeadY = steps[i].headY;
            expScore = steps[i].score;
            expOver  = steps[i].over;
            waitForDraw(i + 2);
            $display("step %0d: head (%0d,%0d) score %0d over %0d: %s", i + 1,
                     expHeadX, expHeadY, expScore, expOver,
                     (errorCount == errorsBefore) ? "ok" : "FAILED");
            errorsBefore = errorCount;
        end

        // gameOver must hold with no further plots
        repeat (100) @(posedge Clock);
        #1;
        if (!endSeen)
        begin
            runErrors++;
            $display("error: the run ended without an end marker");
        end

        $display("%0d steps, %0d checks, %0d errors", stepCount, checkCount,
                 errorCount + runErrors);
        if (errorCount + runErrors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/snakePkg.sv
rtl/scoreDisplay.sv
rtl/collisionCheck.sv
rtl/applePlacer.sv
rtl/snakeBody.sv
rtl/gameSequencer.sv
rtl/snakeTop.sv
dv/snakeChecker.sv
dv/snakeTb.sv

// File: rtl/applePlacer.sv
/*
 * Apple placement and score. The apple walks a fixed table of positions
 * each time the head lands on it; the score counts eats modulo ten.
 */
`timescale 1ns/1ns

module applePlacer
(
    input  logic                  Clock,
    input  logic                  reset,
    input  logic                  checkStep,
    input  snakePkg::xCoord_t     headX,
    input  snakePkg::yCoord_t     headY,
    output snakePkg::xCoord_t     appleX,
    output snakePkg::yCoord_t     appleY,
    output logic                  ateApple,
    output snakePkg::scoreDigit_t score
);

    // position in the table, entry 0 only used after reset
    logic [2:0] appleIdx;

    always_comb
    begin
        case (appleIdx)
            3'd0:    appleX = 8'd30;
            3'd1:    appleX = 8'd10;
            3'd2:    appleX = 8'd70;
            3'd3:    appleX = 8'd60;
            3'd4:    appleX = 8'd20;
            3'd5:    appleX = 8'd50;
            default: appleX = 8'd80;
        endcase
        case (appleIdx)
            3'd0:    appleY = 7'd30;
            3'd1:    appleY = 7'd20;
            3'd2:    appleY = 7'd90;
            3'd3:    appleY = 7'd100;
            3'd4:    appleY = 7'd80;
            3'd5:    appleY = 7'd10;
            default: appleY = 7'd50;
        endcase
    end

    // apple and head share the grid
    assign ateApple = (headX == appleX) && (headY == appleY);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            appleIdx <= 3'd0;
            score    <= '0;
        end
        else if (checkStep && ateApple)
        begin
            // last entry loops back to the second one
            appleIdx <= (appleIdx == 3'd6) ? 3'd1 : appleIdx + 3'd1;
            score    <= (score == 4'd9) ? '0 : score + 4'd1;
        end
    end

endmodule

// File: rtl/collisionCheck.sv
/*
 * Self-hit detector. Compares the head with the body segments it can
 * reach; positions are grid aligned, so equality is a hit.
 */
`timescale 1ns/1ns
`include "snakeParams.svh"

module collisionCheck
(
    input  snakePkg::xCoord_t [`SNAKE_LEN-1:0] segX,
    input  snakePkg::yCoord_t [`SNAKE_LEN-1:0] segY,
    output logic                               hit
);

    always_comb
    begin
        hit = 1'b0;
        // segments 1 and 2 sit next to the head and never overlap it
        for (int i = `FIRST_CHECKED_SEG; i < `SNAKE_LEN; i++)
        begin
            if ((segX[0] == segX[i]) && (segY[0] == segY[i]))
            begin
                hit = 1'b1;
            end
        end
    end

endmodule

// File: rtl/gameSequencer.sv
/*
 * Game sequencer. Times movement steps, latches the direction keys and
 * walks the draw, erase, move and check phases, sweeping one segment
 * block at a time into the pixel write stream.
 */
`timescale 1ns/1ns
`include "snakeParams.svh"

module gameSequencer
(
    input  logic                               Clock,
    input  logic                               reset,
    input  logic [3:0]                         keyN,
    input  logic                               start,
    input  snakePkg::colour_t                  snakeColour,
    input  snakePkg::xCoord_t [`SNAKE_LEN-1:0] segX,
    input  snakePkg::yCoord_t [`SNAKE_LEN-1:0] segY,
    input  snakePkg::xCoord_t                  appleX,
    input  snakePkg::yCoord_t                  appleY,
    input  logic                               hit,
    input  logic                               ateApple,
    output snakePkg::direction_t               direction,
    output logic                               stepMove,
    output logic                               checkStep,
    output logic                               plot,
    output snakePkg::pixelWrite_t              pixel,
    output logic                               gameOver
);
    import snakePkg::*;

    localparam int timerW = $clog2(`STEP_TICKS + 1);
    localparam logic [3:0] lastPix = 4'(`SEG_SIZE - 1);
    localparam logic [2:0] lastSeg = 3'(`SNAKE_LEN - 1);

    seqState_t         state;
    seqState_t         nextState;
    logic [timerW-1:0] stepTimer;
    logic              stepTick;
    logic              tickPending;
    // set once the first key has been seen
    logic              running;
    logic              anyKey;
    // sweep counters inside one block, plus the segment being drawn
    logic [3:0]        pixX;
    logic [3:0]        pixY;
    logic [2:0]        segIdx;
    logic              blockDone;
    logic              lastBlock;
    xCoord_t           originX;
    yCoord_t           originY;
    colour_t           pixColour;

    assign anyKey    = ~&keyN;
    assign stepTick  = (stepTimer == timerW'(`STEP_TICKS - 1));
    assign blockDone = (pixX == lastPix) && (pixY == lastPix);
    assign lastBlock = blockDone && (segIdx == lastSeg);

    // free running step timer
    always_ff @(posedge Clock)
    begin
        if (reset)
            stepTimer <= '0;
        else
            stepTimer <= stepTick ? '0 : stepTimer + 1'b1;
    end

    // a tick during a step is held until the step finishes
    always_ff @(posedge Clock)
    begin
        if (reset || !running)
            tickPending <= 1'b0;
        else if (stepTick)
            tickPending <= 1'b1;
        else if (state == seqWaitTick)
            tickPending <= 1'b0;
    end

    // lowest pressed key wins, direction held when no key is down
    always_ff @(posedge Clock)
    begin
        if (reset)
            direction <= dirUp;
        else if (!keyN[0])
            direction <= dirRight;
        else if (!keyN[1])
            direction <= dirDown;
        else if (!keyN[2])
            direction <= dirUp;
        else if (!keyN[3])
            direction <= dirLeft;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            seqIdle:     if (start) nextState = seqApple;
            seqApple:    if (blockDone) nextState = seqSnake;
            seqSnake:    if (lastBlock) nextState = running ? seqWaitTick : seqWaitKey;
            seqWaitKey:  if (anyKey) nextState = seqWaitTick;
            seqWaitTick: if (tickPending) nextState = seqErase;
            seqErase:    if (lastBlock) nextState = seqMove;
            seqMove:     nextState = seqCheck;
            seqCheck:
            begin
                if (hit)
                    nextState = seqEnd;
                else if (ateApple)
                    nextState = seqApple;
                else
                    nextState = seqSnake;
            end
            seqEnd:      if (blockDone) nextState = seqOver;
            default:     nextState = state;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state   <= seqIdle;
            running <= 1'b0;
            pixX    <= '0;
            pixY    <= '0;
            segIdx  <= '0;
        end
        else
        begin
            state <= nextState;
            if (state == seqWaitKey && anyKey)
                running <= 1'b1;
            // counters step on every plotted pixel, row by row
            if (plot)
            begin
                pixX <= (pixX == lastPix) ? '0 : pixX + 4'd1;
                if (pixX == lastPix)
                    pixY <= (pixY == lastPix) ? '0 : pixY + 4'd1;
            end
            // next segment after each full block of the body
            if (blockDone && (state == seqSnake || state == seqErase))
                segIdx <= (segIdx == lastSeg) ? '0 : segIdx + 3'd1;
        end
    end

    // block origin and colour for the current phase
    always_comb
    begin
        originX   = segX[segIdx];
        originY   = segY[segIdx];
        pixColour = snakeColour;
        case (state)
            seqApple:
            begin
                originX   = appleX;
                originY   = appleY;
                pixColour = `APPLE_COLOUR;
            end
            seqErase:
                pixColour = `ERASE_COLOUR;
            seqEnd:
            begin
                // end marker over the head that hit
                originX   = segX[0];
                originY   = segY[0];
                pixColour = `END_COLOUR;
            end
            default:
                pixColour = snakeColour;
        endcase
    end

    assign plot = (state == seqApple) || (state == seqSnake) ||
                  (state == seqErase) || (state == seqEnd);

    assign pixel.x      = originX + xCoord_t'(pixX);
    assign pixel.y      = originY + yCoord_t'(pixY);
    assign pixel.colour = pixColour;

    assign stepMove  = (state == seqMove);
    assign checkStep = (state == seqCheck);
    assign gameOver  = (state == seqOver);

endmodule

// File: rtl/scoreDisplay.sv
/*
 * Score decoder. Turns the decimal score into active-low segments,
 * segment 0 on top, going clockwise, segment 6 in the middle.
 */
`timescale 1ns/1ns

module scoreDisplay
(
    input  snakePkg::scoreDigit_t score,
    output logic [6:0]            scoreSegments
);

    always_comb
    begin
        case (score)
            4'd0:    scoreSegments = 7'b1000000;
            4'd1:    scoreSegments = 7'b1111001;
            4'd2:    scoreSegments = 7'b0100100;
            4'd3:    scoreSegments = 7'b0110000;
            4'd4:    scoreSegments = 7'b0011001;
            4'd5:    scoreSegments = 7'b0010010;
            4'd6:    scoreSegments = 7'b0000010;
            4'd7:    scoreSegments = 7'b1111000;
            4'd8:    scoreSegments = 7'b0000000;
            4'd9:    scoreSegments = 7'b0011000;
            // blank for codes above nine
            default: scoreSegments = 7'b1111111;
        endcase
    end

endmodule

// File: rtl/snakeBody.sv
/*
 * Snake body register. One position per segment; on each move strobe the
 * body shifts one slot and the head steps one segment, wrapping at edges.
 */
`timescale 1ns/1ns
`include "snakeParams.svh"

module snakeBody
(
    input  logic                               Clock,
    input  logic                               reset,
    input  logic                               stepMove,
    input  snakePkg::direction_t               direction,
    output snakePkg::xCoord_t [`SNAKE_LEN-1:0] segX,
    output snakePkg::yCoord_t [`SNAKE_LEN-1:0] segY
);
    import snakePkg::*;

    // last grid positions before the wrap
    localparam xCoord_t lastX = xCoord_t'(`SCREEN_W - `SEG_SIZE);
    localparam yCoord_t lastY = yCoord_t'(`SCREEN_H - `SEG_SIZE);
    localparam xCoord_t stepX = xCoord_t'(`SEG_SIZE);
    localparam yCoord_t stepY = yCoord_t'(`SEG_SIZE);

    xCoord_t nextX;
    yCoord_t nextY;

    // new head position from the latched direction
    always_comb
    begin
        nextX = segX[0];
        nextY = segY[0];
        case (direction)
            dirRight:
                nextX = (segX[0] == lastX) ? '0 : segX[0] + stepX;
            dirLeft:
                nextX = (segX[0] == '0) ? lastX : segX[0] - stepX;
            dirDown:
                nextY = (segY[0] == lastY) ? '0 : segY[0] + stepY;
            dirUp:
                nextY = (segY[0] == '0) ? lastY : segY[0] - stepY;
            default:
                nextX = segX[0];
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // straight column below the head
            for (int i = 0; i < `SNAKE_LEN; i++)
            begin
                segX[i] <= xCoord_t'(`HEAD_X0);
                segY[i] <= yCoord_t'(`HEAD_Y0 + i * `SEG_SIZE);
            end
        end
        else if (stepMove)
        begin
            // each segment takes the place of the one ahead
            for (int i = `SNAKE_LEN - 1; i > 0; i--)
            begin
                segX[i] <= segX[i-1];
                segY[i] <= segY[i-1];
            end
            segX[0] <= nextX;
            segY[0] <= nextY;
        end
    end

endmodule

// File: rtl/snakeParams.svh
/*
 * Snake engine constants: screen geometry, segment size, snake length,
 * drawing colours, step period and the starting head position.
 */
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

// screen in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// one square segment, also the apple size
`define SEG_SIZE 10
`define SNAKE_LEN 6
// head cannot reach the first two body segments in one step
`define FIRST_CHECKED_SEG 3

// starting head, body runs straight down from here
`define HEAD_X0 80
`define HEAD_Y0 60

// clocks between movement steps, raise for real hardware
`define STEP_TICKS 20

`define APPLE_COLOUR 3'b100
`define ERASE_COLOUR 3'b000
`define END_COLOUR 3'b101

`endif

// File: rtl/snakePkg.sv
/*
 * Shared types for the snake engine: coordinates, colours, score digit,
 * movement direction, the pixel write record and the sequencer states.
 */
package snakePkg;

    // pixel column and row on the 160x120 screen
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;

    // one bit each for red, green, blue
    typedef logic [2:0] colour_t;

    // decimal score, 0 to 9
    typedef logic [3:0] scoreDigit_t;

    typedef enum logic [1:0] {
        dirRight,
        dirDown,
        dirUp,
        dirLeft
    } direction_t;

    // one write into the frame buffer
    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
        colour_t colour;
    } pixelWrite_t;

    typedef enum logic [3:0] {
        seqIdle,
        seqApple,
        seqSnake,
        seqWaitKey,
        seqWaitTick,
        seqErase,
        seqMove,
        seqCheck,
        seqEnd,
        seqOver
    } seqState_t;

endpackage

// File: rtl/snakeTop.sv
/*
 * Snake game engine top level. Connects the sequencer, snake body,
 * self-hit check, apple placer and score decoder; emits a pixel stream.
 */
`timescale 1ns/1ns
`include "snakeParams.svh"

module snakeTop
(
    input  logic                  Clock,
    input  logic                  reset,
    input  logic [3:0]            keyN,
    input  snakePkg::colour_t     snakeColour,
    input  logic                  start,
    output logic                  plot,
    output snakePkg::pixelWrite_t pixel,
    output logic [6:0]            scoreSegments,
    output logic                  gameOver
);
    import snakePkg::*;

    // segment positions, index 0 is the head
    xCoord_t [`SNAKE_LEN-1:0] segX;
    yCoord_t [`SNAKE_LEN-1:0] segY;
    xCoord_t                  appleX;
    yCoord_t                  appleY;
    direction_t               direction;
    // step strobes from the sequencer
    logic                     stepMove;
    logic                     checkStep;
    logic                     hit;
    logic                     ateApple;
    scoreDigit_t              score;

    gameSequencer sequencer
    (
        .Clock       (Clock),
        .reset       (reset),
        .keyN        (keyN),
        .start       (start),
        .snakeColour (snakeColour),
        .segX        (segX),
        .segY        (segY),
        .appleX      (appleX),
        .appleY      (appleY),
        .hit         (hit),
        .ateApple    (ateApple),
        .direction   (direction),
        .stepMove    (stepMove),
        .checkStep   (checkStep),
        .plot        (plot),
        .pixel       (pixel),
        .gameOver    (gameOver)
    );

    snakeBody body
    (
        .Clock     (Clock),
        .reset     (reset),
        .stepMove  (stepMove),
        .direction (direction),
        .segX      (segX),
        .segY      (segY)
    );

    collisionCheck collision
    (
        .segX (segX),
        .segY (segY),
        .hit  (hit)
    );

    // only the head can land on the apple
    applePlacer apple
    (
        .Clock     (Clock),
        .reset     (reset),
        .checkStep (checkStep),
        .headX     (segX[0]),
        .headY     (segY[0]),
        .appleX    (appleX),
        .appleY    (appleY),
        .ateApple  (ateApple),
        .score     (score)
    );

    scoreDisplay display
    (
        .score         (score),
        .scoreSegments (scoreSegments)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build the snake engine testbench with Verilator and run it.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module snakeTb -o snakeSim \
    > build.log 2>&1 &&
./obj_dir/snakeSim > sim.log 2>&1

grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
